//--- verilog/kem_ctrl_pkg.sv
`default_nettype none

package kem_ctrl_pkg;

  ////////////////////////////////////////
  // Commands and phases
  ////////////////////////////////////////

  // Encoding kept compatible with the full command set
  typedef enum logic [2:0] {
    cmd_no_cmd      = 3'd0,
    cmd_keygen      = 3'd2,
    cmd_setup_test  = 3'd5,
    cmd_add_entropy = 3'd6
  } top_cmd_e;

  typedef enum logic [3:0] {
    ph_gen_a             = 4'd0,
    ph_keygen_prng       = 4'd1,
    ph_keygen_mid        = 4'd2,
    ph_keygen_post_gen_a = 4'd3,
    ph_setup_test        = 4'd4,
    ph_add_entropy       = 4'd5
  } phase_e;

  // Longest phase and longest phase list
  localparam int MAX_STEPS  = 10;
  localparam int MAX_PHASES = 4;

  typedef logic [15:0] row_idx_t;

  ////////////////////////////////////////
  // Step descriptors
  ////////////////////////////////////////

  typedef enum logic [3:0] {
    sk_generic     = 4'd0,
    sk_ki_byte     = 4'd1,
    sk_ki_zeros    = 4'd2,
    sk_k_single    = 4'd3,
    sk_k_long_out  = 4'd4,
    sk_k_long_in   = 4'd5,
    sk_k_out_state = 4'd6,
    sk_k_in_state  = 4'd7,
    sk_m           = 4'd8,
    sk_gen_a_k_out = 4'd9
  } step_kind_e;

  // Hub endpoints
  typedef logic [3:0] hub_unit_t;
  localparam hub_unit_t HUB_NONE        = 4'b0000;
  localparam hub_unit_t HUB_KECCAK      = 4'b0001;
  localparam hub_unit_t HUB_OUTER       = 4'b0010;
  localparam hub_unit_t HUB_MEM_AND_MUL = 4'b0100;
  localparam hub_unit_t HUB_SEED_A      = 4'b1000;

  typedef logic [4:0] mem_cmd_t;
  localparam mem_cmd_t MEM_NONE               = 5'd0;
  localparam mem_cmd_t MEM_OUT_RNG_STATE      = 5'd1;
  localparam mem_cmd_t MEM_IN_RNG_STATE       = 5'd2;
  localparam mem_cmd_t MEM_IN_SEED_SE         = 5'd3;
  localparam mem_cmd_t MEM_OUT_SEED_SE        = 5'd4;
  localparam mem_cmd_t MEM_IN_S_ROW_FIRST     = 5'd5;
  localparam mem_cmd_t MEM_IN_B_COL_FIRST     = 5'd6;
  localparam mem_cmd_t MEM_OUT_B_COL_FIRST    = 5'd7;
  localparam mem_cmd_t MEM_IN_U               = 5'd8;
  localparam mem_cmd_t MEM_IN_SALT            = 5'd9;
  // B += S * A^T with A streamed in row by row
  localparam mem_cmd_t MEM_BPLEQ_S_TIMES_IN_AT = 5'd10;

  // Byte for the hash input or a permutation cycle count
  typedef logic [8:0] step_param_t;

  typedef struct packed {
    step_kind_e  kind;
    logic        k_is_last;
    logic        k_is_sampled;
    step_param_t param;
    mem_cmd_t    m_cmd;
    hub_unit_t   h_dst;
    hub_unit_t   h_src;
  } step_desc_t;

  ////////////////////////////////////////
  // Core command word
  ////////////////////////////////////////

  typedef logic [7:0] core_unit_mask_t;
  localparam core_unit_mask_t UNIT_K_IN  = 8'b1000_0000;
  localparam core_unit_mask_t UNIT_K_OUT = 8'b0100_0000;
  localparam core_unit_mask_t UNIT_O_OUT = 8'b0010_0000;
  localparam core_unit_mask_t UNIT_O_IN  = 8'b0001_0000;
  localparam core_unit_mask_t UNIT_M     = 8'b0000_1000;
  localparam core_unit_mask_t UNIT_S     = 8'b0000_0100;
  localparam core_unit_mask_t UNIT_H     = 8'b0000_0010;
  localparam core_unit_mask_t UNIT_K     = 8'b0000_0001;

  typedef logic [9:0] o_len_t;

  typedef logic [1:0] ki_mode_t;
  localparam ki_mode_t KI_FORWARD    = 2'd0;
  localparam ki_mode_t KI_SEND_BYTE  = 2'd1;
  localparam ki_mode_t KI_SEND_ZEROS = 2'd2;

  typedef logic [3:0] k_mode_t;
  localparam k_mode_t K_MODE_PLAIN     = 4'b0000;
  localparam k_mode_t K_MODE_LONG_IN   = 4'b0001;
  localparam k_mode_t K_MODE_OUT_STATE = 4'b0011;
  localparam k_mode_t K_MODE_IN_STATE  = 4'b0100;
  localparam k_mode_t K_MODE_GEN_A     = 4'b1000;

  typedef struct packed {
    o_len_t      o_in_len;
    o_len_t      o_out_len;
    logic [7:0]  k_in_byte;
    logic        k_in_not_last;
    ki_mode_t    k_in_mode;
    logic        k_out_not_last;
    logic        k_out_sampled;
    hub_unit_t   h_dst;
    hub_unit_t   h_src;
    mem_cmd_t    m_cmd;
    k_mode_t     k_mode;
    step_param_t k_cycles;
    logic        k_flag;
    logic        s_in;
    logic        s_out;
  } core_cmd_t;

endpackage

`default_nettype wire

//--- verilog/step_counter.sv
`default_nettype none

module step_counter #(
  parameter int MAX_STEPS = 10
) (
  input  wire                           i_clk,
  input  wire                           i_rst_n,
  input  wire                           i_restart,
  input  wire [$clog2(MAX_STEPS+1)-1:0] i_num_steps,
  input  wire                           i_consume,
  output logic                          o_busy,
  output logic [MAX_STEPS-1:0]          o_step,
  output logic                          o_last
);

  localparam int CNT_W = $clog2(MAX_STEPS + 1);

  logic [CNT_W-1:0]     num_steps_q;
  logic [MAX_STEPS-1:0] last_step;

  // One-hot position of the final step
  assign last_step = {{(MAX_STEPS-1){1'b0}}, 1'b1} << (num_steps_q - CNT_W'(1));
  assign o_last    = o_busy && (o_step == last_step);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_busy      <= 1'b0;
      o_step      <= '0;
      num_steps_q <= '0;
    end else if (i_restart) begin
      o_busy      <= 1'b1;
      o_step      <= {{(MAX_STEPS-1){1'b0}}, 1'b1};
      num_steps_q <= i_num_steps;
    end else if (o_busy && i_consume) begin
      if (o_last) begin
        o_busy <= 1'b0;
        o_step <= '0;
      end else begin
        o_step <= o_step << 1;
      end
    end
  end

  // The next phase is only started once this one has drained
  assert property (@(posedge i_clk) disable iff (!i_rst_n) i_restart |-> !o_busy);

endmodule

`default_nettype wire

//--- verilog/phase_decoder.sv
`default_nettype none

module phase_decoder #(
  parameter int NUM_ROWS = 1344
) (
  input  wire                         i_clk,
  input  wire                         i_rst_n,
  input  wire kem_ctrl_pkg::top_cmd_e i_cmd,
  output logic                        o_cmd_can_receive,
  output kem_ctrl_pkg::phase_e        o_phase,
  output logic                        o_phase_start,
  output kem_ctrl_pkg::row_idx_t      o_row_idx,
  input  wire                         i_phase_done
);

  import kem_ctrl_pkg::*;

  localparam int IDX_W = $clog2(MAX_PHASES);
  typedef logic [IDX_W-1:0] phase_idx_t;

  // Slot of the row generation phase in the keygen list
  localparam phase_idx_t GEN_A_IDX = phase_idx_t'(2);

  top_cmd_e   cmd_q;
  phase_idx_t idx_q;
  logic       test_q;
  logic       accept;
  logic       in_gen_a;
  logic       more_rows;
  phase_idx_t first_idx;

  function automatic phase_e phase_of(top_cmd_e cmd, phase_idx_t idx);
    phase_e ph;
    ph = ph_add_entropy;
    if (cmd == cmd_setup_test) begin
      ph = ph_setup_test;
    end else if (cmd == cmd_keygen) begin
      case (idx)
        phase_idx_t'(0): ph = ph_keygen_prng;
        phase_idx_t'(1): ph = ph_keygen_mid;
        GEN_A_IDX:       ph = ph_gen_a;
        default:         ph = ph_keygen_post_gen_a;
      endcase
    end
    return ph;
  endfunction

  function automatic phase_idx_t last_idx(top_cmd_e cmd);
    return (cmd == cmd_keygen) ? phase_idx_t'(MAX_PHASES - 1) : phase_idx_t'(0);
  endfunction

  assign accept    = o_cmd_can_receive && (i_cmd != cmd_no_cmd);
  // A test run of keygen starts at the mid phase
  assign first_idx = (i_cmd == cmd_keygen && test_q) ? phase_idx_t'(1) : phase_idx_t'(0);
  assign in_gen_a  = (cmd_q == cmd_keygen) && (idx_q == GEN_A_IDX);
  assign more_rows = in_gen_a && (o_row_idx != row_idx_t'(NUM_ROWS - 1));

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_cmd_can_receive <= 1'b1;
      cmd_q             <= cmd_no_cmd;
      idx_q             <= '0;
      test_q            <= 1'b0;
      o_phase           <= ph_gen_a;
      o_phase_start     <= 1'b0;
      o_row_idx         <= '0;
    end else begin
      o_phase_start <= 1'b0;
      if (accept) begin
        o_cmd_can_receive <= 1'b0;
        cmd_q             <= i_cmd;
        idx_q             <= first_idx;
        test_q            <= 1'b0;
        o_phase           <= phase_of(i_cmd, first_idx);
        o_phase_start     <= 1'b1;
        o_row_idx         <= '0;
      end else if (i_phase_done) begin
        if (in_gen_a) begin
          o_row_idx <= o_row_idx + 1'b1;
        end
        if (more_rows) begin
          // Same phase again for the next matrix row
          o_phase_start <= 1'b1;
        end else if (idx_q != last_idx(cmd_q)) begin
          idx_q         <= idx_q + 1'b1;
          o_phase       <= phase_of(cmd_q, idx_q + 1'b1);
          o_phase_start <= 1'b1;
        end else begin
          o_cmd_can_receive <= 1'b1;
          test_q            <= (cmd_q == cmd_setup_test);
        end
      end
    end
  end

  // The host keeps the command idle while one is running
  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !o_cmd_can_receive |-> (i_cmd == cmd_no_cmd));

endmodule

`default_nettype wire

//--- verilog/step_sequencer.sv
`default_nettype none

module step_sequencer (
  input  wire                         i_clk,
  input  wire                         i_rst_n,
  input  wire kem_ctrl_pkg::phase_e   i_phase,
  input  wire                         i_phase_start,
  input  wire kem_ctrl_pkg::row_idx_t i_row_idx,
  input  wire                         i_consume,
  output kem_ctrl_pkg::step_desc_t    o_step,
  output logic                        o_step_valid,
  output logic                        o_phase_done
);

  import kem_ctrl_pkg::*;

  localparam int CNT_W = $clog2(MAX_STEPS + 1);

  logic [CNT_W-1:0]     num_steps;
  logic [MAX_STEPS-1:0] step_oh;
  logic [CNT_W-1:0]     idx;
  logic                 last;

  // Keccak, ki and memory ops that do not move data over the hub
  function automatic step_desc_t op(step_kind_e kind, step_param_t param, mem_cmd_t m_cmd);
    return '{kind, 1'b0, 1'b0, param, m_cmd, HUB_NONE, HUB_NONE};
  endfunction

  // Hub transfer from src to dst
  function automatic step_desc_t mv(hub_unit_t dst, hub_unit_t src, mem_cmd_t m_cmd,
                                    logic is_last, logic sampled);
    return '{sk_generic, is_last, sampled, 9'd0, m_cmd, dst, src};
  endfunction

  always_comb begin
    case (i_phase)
      ph_gen_a:             num_steps = CNT_W'(4);
      ph_keygen_prng:       num_steps = CNT_W'(10);
      ph_keygen_mid:        num_steps = CNT_W'(9);
      ph_keygen_post_gen_a: num_steps = CNT_W'(4);
      ph_setup_test:        num_steps = CNT_W'(4);
      default:              num_steps = CNT_W'(5);
    endcase
  end

  step_counter #(
    .MAX_STEPS(MAX_STEPS)
  ) u_step_counter (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_restart  (i_phase_start),
    .i_num_steps(num_steps),
    .i_consume  (i_consume),
    .o_busy     (o_step_valid),
    .o_step     (step_oh),
    .o_last     (last)
  );

  assign o_phase_done = o_step_valid && last && i_consume;

  always_comb begin
    idx = '0;
    for (int i = 0; i < MAX_STEPS; i++) begin
      if (step_oh[i]) idx = CNT_W'(i);
    end
  end

  ////////////////////////////////////////
  // Step tables
  ////////////////////////////////////////

  always_comb begin
    o_step = op(sk_generic, '0, MEM_NONE);
    case (i_phase)
      ph_gen_a: begin
        case (idx)
          0: o_step = op(sk_ki_byte, {1'b0, i_row_idx[7:0]}, MEM_NONE);
          1: o_step = op(sk_ki_byte, {1'b0, i_row_idx[15:8]}, MEM_NONE);
          2: o_step = mv(HUB_KECCAK, HUB_SEED_A, MEM_NONE, 1'b1, 1'b0);
          3: begin
            o_step      = mv(HUB_MEM_AND_MUL, HUB_KECCAK, MEM_NONE, 1'b0, 1'b0);
            o_step.kind = sk_gen_a_k_out;
          end
        endcase
      end
      ph_keygen_prng: begin
        // seedSE and seedA from the RNG state, then the state is refreshed
        case (idx)
          0: o_step = op(sk_ki_byte, 9'h00, MEM_NONE);
          1: o_step = mv(HUB_KECCAK, HUB_MEM_AND_MUL, MEM_OUT_RNG_STATE, 1'b1, 1'b0);
          2: o_step = op(sk_k_single, '0, MEM_NONE);
          3: o_step = mv(HUB_OUTER, HUB_KECCAK, MEM_NONE, 1'b0, 1'b0);
          4: o_step = mv(HUB_MEM_AND_MUL, HUB_KECCAK, MEM_IN_SEED_SE, 1'b0, 1'b0);
          5: o_step = mv(HUB_SEED_A, HUB_KECCAK, MEM_NONE, 1'b1, 1'b0);
          6: o_step = op(sk_k_single, '0, MEM_NONE);
          7: o_step = op(sk_ki_byte, 9'h01, MEM_NONE);
          8: o_step = mv(HUB_KECCAK, HUB_MEM_AND_MUL, MEM_OUT_RNG_STATE, 1'b1, 1'b0);
          9: o_step = mv(HUB_MEM_AND_MUL, HUB_KECCAK, MEM_IN_RNG_STATE, 1'b1, 1'b0);
        endcase
      end
      ph_keygen_mid: begin
        // Sample S and E, hash seedA, then queue the multiply
        case (idx)
          0: o_step = op(sk_k_long_out, 9'd317, MEM_NONE);
          1: o_step = op(sk_ki_byte, 9'h5f, MEM_NONE);
          2: o_step = mv(HUB_KECCAK, HUB_MEM_AND_MUL, MEM_OUT_SEED_SE, 1'b1, 1'b0);
          3: o_step = mv(HUB_MEM_AND_MUL, HUB_KECCAK, MEM_IN_S_ROW_FIRST, 1'b0, 1'b1);
          4: o_step = mv(HUB_MEM_AND_MUL, HUB_KECCAK, MEM_IN_B_COL_FIRST, 1'b1, 1'b1);
          5: o_step = op(sk_k_single, '0, MEM_NONE);
          6: o_step = mv(HUB_KECCAK, HUB_SEED_A, MEM_NONE, 1'b1, 1'b0);
          7: o_step = mv(HUB_SEED_A, HUB_KECCAK, MEM_NONE, 1'b1, 1'b0);
          8: o_step = op(sk_m, '0, MEM_BPLEQ_S_TIMES_IN_AT);
        endcase
      end
      ph_keygen_post_gen_a: begin
        // Public key hash over seedA and B
        case (idx)
          0: o_step = op(sk_k_long_in, 9'd159, MEM_NONE);
          1: o_step = mv(HUB_KECCAK, HUB_SEED_A, MEM_NONE, 1'b0, 1'b0);
          2: o_step = mv(HUB_KECCAK, HUB_MEM_AND_MUL, MEM_OUT_B_COL_FIRST, 1'b1, 1'b0);
          3: o_step = mv(HUB_OUTER, HUB_KECCAK, MEM_NONE, 1'b1, 1'b0);
        endcase
      end
      ph_setup_test: begin
        case (idx)
          0: o_step = mv(HUB_MEM_AND_MUL, HUB_OUTER, MEM_IN_SEED_SE, 1'b0, 1'b0);
          1: o_step = mv(HUB_MEM_AND_MUL, HUB_OUTER, MEM_IN_U, 1'b0, 1'b0);
          2: o_step = mv(HUB_MEM_AND_MUL, HUB_OUTER, MEM_IN_SALT, 1'b0, 1'b0);
          3: o_step = mv(HUB_SEED_A, HUB_OUTER, MEM_NONE, 1'b0, 1'b0);
        endcase
      end
      default: begin
        // Fold 512 outside bits into the RNG state
        case (idx)
          0: o_step = op(sk_k_single, '0, MEM_NONE);
          1: o_step = op(sk_ki_byte, 9'h05, MEM_NONE);
          2: o_step = mv(HUB_KECCAK, HUB_MEM_AND_MUL, MEM_OUT_RNG_STATE, 1'b0, 1'b0);
          3: o_step = mv(HUB_KECCAK, HUB_OUTER, MEM_NONE, 1'b1, 1'b0);
          4: o_step = mv(HUB_MEM_AND_MUL, HUB_KECCAK, MEM_IN_RNG_STATE, 1'b1, 1'b0);
        endcase
      end
    endcase
  end

  // A valid step always lies inside its phase table
  assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_step_valid |-> (o_step.kind != sk_generic) || (o_step.h_dst != HUB_NONE) ||
                     (o_step.h_src != HUB_NONE));

endmodule

`default_nettype wire

//--- verilog/core_cmd_expander.sv
`default_nettype none

module core_cmd_expander (
  input  wire kem_ctrl_pkg::step_desc_t  i_step,
  input  wire                            i_step_valid,
  output kem_ctrl_pkg::core_cmd_t        o_core_cmd,
  output kem_ctrl_pkg::core_unit_mask_t  o_core_has_any
);

  import kem_ctrl_pkg::*;

  core_unit_mask_t mask_raw;
  hub_unit_t       hub_any;
  logic            k_run;
  logic            o2k;
  logic            k2o;

  assign hub_any = i_step.h_dst | i_step.h_src;
  // Kinds that run the permutation itself
  assign k_run   = i_step.kind inside {sk_k_single, sk_k_long_out, sk_k_long_in,
                                       sk_k_out_state, sk_k_in_state};
  assign o2k     = (i_step.h_dst == HUB_KECCAK) && (i_step.h_src == HUB_OUTER);
  assign k2o     = (i_step.h_dst == HUB_OUTER) && (i_step.h_src == HUB_KECCAK);

  ////////////////////////////////////////
  // Unit mask
  ////////////////////////////////////////

  assign mask_raw = (|(i_step.h_dst & HUB_KECCAK) ? UNIT_K_IN : '0)
                  | (|(i_step.h_src & HUB_KECCAK) ? UNIT_K_OUT : '0)
                  | (|(i_step.h_dst & HUB_OUTER) ? UNIT_O_OUT : '0)
                  | (|(i_step.h_src & HUB_OUTER) ? UNIT_O_IN : '0)
                  | (|(hub_any & HUB_MEM_AND_MUL) ? UNIT_M : '0)
                  | (|(hub_any & HUB_SEED_A) ? UNIT_S : '0)
                  | (|hub_any ? UNIT_H : '0)
                  | (i_step.kind inside {sk_ki_byte, sk_ki_zeros} ? UNIT_K_IN : '0)
                  | (k_run ? UNIT_K : '0)
                  | ((i_step.kind == sk_m) ? UNIT_M : '0)
                  | ((i_step.kind == sk_gen_a_k_out) ? (UNIT_K | UNIT_H | UNIT_K_OUT) : '0);

  assign o_core_has_any = i_step_valid ? mask_raw : '0;

  ////////////////////////////////////////
  // Command word
  ////////////////////////////////////////

  always_comb begin
    o_core_cmd                = '0;
    o_core_cmd.o_in_len       = o2k ? o_len_t'(16) : o_len_t'(0);
    o_core_cmd.o_out_len      = k2o ? o_len_t'(4) : o_len_t'(0);
    o_core_cmd.k_in_byte      = i_step.param[7:0];
    o_core_cmd.k_in_not_last  = ~i_step.k_is_last;
    o_core_cmd.k_in_mode      = (i_step.kind == sk_ki_byte)  ? KI_SEND_BYTE :
                                (i_step.kind == sk_ki_zeros) ? KI_SEND_ZEROS : KI_FORWARD;
    o_core_cmd.k_out_not_last = ~i_step.k_is_last;
    o_core_cmd.k_out_sampled  = i_step.k_is_sampled;
    o_core_cmd.h_dst          = i_step.h_dst;
    o_core_cmd.h_src          = i_step.h_src;
    o_core_cmd.m_cmd          = i_step.m_cmd;
    o_core_cmd.s_in           = |(i_step.h_dst & HUB_SEED_A);
    o_core_cmd.s_out          = |(i_step.h_src & HUB_SEED_A);

    // Keccak mode, cycle count and run flag
    case (i_step.kind)
      sk_gen_a_k_out: begin
        o_core_cmd.k_mode   = K_MODE_GEN_A;
        o_core_cmd.k_cycles = 9'd8;
        o_core_cmd.k_flag   = 1'b1;
      end
      sk_k_single: begin
        o_core_cmd.k_mode   = K_MODE_PLAIN;
        o_core_cmd.k_cycles = 9'd1;
        o_core_cmd.k_flag   = 1'b1;
      end
      sk_k_long_in: begin
        o_core_cmd.k_mode   = K_MODE_LONG_IN;
        o_core_cmd.k_cycles = i_step.param;
        o_core_cmd.k_flag   = 1'b1;
      end
      sk_k_long_out: begin
        o_core_cmd.k_mode   = K_MODE_PLAIN;
        o_core_cmd.k_cycles = i_step.param;
        o_core_cmd.k_flag   = 1'b1;
      end
      sk_k_out_state: begin
        o_core_cmd.k_mode   = K_MODE_OUT_STATE;
        o_core_cmd.k_cycles = 9'd160;
      end
      sk_k_in_state: begin
        o_core_cmd.k_mode   = K_MODE_IN_STATE;
        o_core_cmd.k_cycles = 9'd1;
        o_core_cmd.k_flag   = 1'b1;
      end
      default: begin
        o_core_cmd.k_mode = K_MODE_PLAIN;
      end
    endcase
  end

  // A valid step from the sequencer always reaches some unit
  always_comb begin
    if (i_step_valid) begin
      assert (mask_raw != '0);
    end
  end

endmodule

`default_nettype wire

//--- verilog/kem_ctrl_top.sv
`default_nettype none

module kem_ctrl_top #(
  parameter int NUM_ROWS = 1344
) (
  input  wire                           i_clk,
  input  wire                           i_rst_n,
  input  wire kem_ctrl_pkg::top_cmd_e   i_cmd,
  output logic                          o_cmd_can_receive,
  output kem_ctrl_pkg::core_cmd_t       o_core_cmd,
  output kem_ctrl_pkg::core_unit_mask_t o_core_has_any,
  input  wire                           i_core_consume
);

  import kem_ctrl_pkg::*;

  phase_e     phase;
  logic       phase_start;
  logic       phase_done;
  row_idx_t   row_idx;
  step_desc_t step_desc;
  logic       step_valid;

  // Decode: command to phases
  phase_decoder #(
    .NUM_ROWS(NUM_ROWS)
  ) u_phase_decoder (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_cmd            (i_cmd),
    .o_cmd_can_receive(o_cmd_can_receive),
    .o_phase          (phase),
    .o_phase_start    (phase_start),
    .o_row_idx        (row_idx),
    .i_phase_done     (phase_done)
  );

  // Execute: phase to steps
  step_sequencer u_step_sequencer (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_phase      (phase),
    .i_phase_start(phase_start),
    .i_row_idx    (row_idx),
    .i_consume    (i_core_consume),
    .o_step       (step_desc),
    .o_step_valid (step_valid),
    .o_phase_done (phase_done)
  );

  // Result: step to core word and unit mask
  core_cmd_expander u_core_cmd_expander (
    .i_step        (step_desc),
    .i_step_valid  (step_valid),
    .o_core_cmd    (o_core_cmd),
    .o_core_has_any(o_core_has_any)
  );

endmodule

`default_nettype wire

//--- sim/kem_ctrl_ref.svh
`ifndef KEM_CTRL_REF_SVH
`define KEM_CTRL_REF_SVH

////////////////////////////////////////
// Expected unit masks per step
////////////////////////////////////////

// Bit order k_in k_out o_out o_in m s h k
localparam core_unit_mask_t PRNG_MASKS [10] = '{
  8'h80, 8'h8A, 8'h01, 8'h62, 8'h4A, 8'h46, 8'h01, 8'h80, 8'h8A, 8'h4A
};
localparam core_unit_mask_t MID_MASKS [9] = '{
  8'h01, 8'h80, 8'h8A, 8'h4A, 8'h4A, 8'h01, 8'h86, 8'h46, 8'h08
};
localparam core_unit_mask_t GEN_A_MASKS [4] = '{8'h80, 8'h80, 8'h86, 8'h4B};
localparam core_unit_mask_t POST_MASKS [4] = '{8'h01, 8'h86, 8'h8A, 8'h62};
localparam core_unit_mask_t SETUP_MASKS [4] = '{8'h1A, 8'h1A, 8'h1A, 8'h16};
localparam core_unit_mask_t ENTROPY_MASKS [5] = '{8'h01, 8'h80, 8'h8A, 8'h92, 8'h4A};

typedef struct packed {
  core_unit_mask_t mask;
  logic            has_byte;
  step_param_t     byte_val;
} exp_step_t;

function automatic row_idx_t expected_count(top_cmd_e c, logic test_run, int rows);
  int n;
  n = 5;
  if (c == cmd_setup_test) begin
    n = 4;
  end else if (c == cmd_keygen) begin
    n = (test_run ? 0 : 10) + 9 + 4 * rows + 4;
  end
  return row_idx_t'(n);
endfunction

function automatic exp_step_t expected_step(top_cmd_e c, logic test_run, int rows, int n);
  exp_step_t e;
  int        pos;
  row_idx_t  row;
  e   = '0;
  pos = n;
  if (c == cmd_add_entropy) begin
    e.mask = ENTROPY_MASKS[n];
    if (n == 1) begin
      e.has_byte = 1'b1;
      e.byte_val = 9'h05;
    end
  end else if (c == cmd_setup_test) begin
    e.mask = SETUP_MASKS[n];
  end else begin
    // Keygen walks prng, mid, one genA per row, then post
    if (!test_run && pos < 10) return '{PRNG_MASKS[pos], 1'b0, 9'd0};
    if (!test_run) pos = pos - 10;
    if (pos < 9) return '{MID_MASKS[pos], 1'b0, 9'd0};
    pos = pos - 9;
    if (pos < 4 * rows) begin
      row    = row_idx_t'(pos / 4);
      e.mask = GEN_A_MASKS[pos % 4];
      // Row counter goes to the hash low byte first
      if (pos % 4 == 0) begin
        e.has_byte = 1'b1;
        e.byte_val = {1'b0, row[7:0]};
      end else if (pos % 4 == 1) begin
        e.has_byte = 1'b1;
        e.byte_val = {1'b0, row[15:8]};
      end
    end else begin
      e.mask = POST_MASKS[pos - 4 * rows];
    end
  end
  return e;
endfunction

function automatic logic [31:0] xorshift32(logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

task automatic check_mask(string what, core_unit_mask_t got, core_unit_mask_t exp);
  if (got !== exp) begin
    $display("MISMATCH at %0t: %s mask %h, expected %h", $time, what, got, exp);
    stop_on_error();
  end
endtask

task automatic check_cmd_field(string what, step_param_t got, step_param_t exp);
  if (got !== exp) begin
    $display("MISMATCH at %0t: %s field %h, expected %h", $time, what, got, exp);
    stop_on_error();
  end
endtask

task automatic check_hub(string what, hub_unit_t got, hub_unit_t exp);
  if (got !== exp) begin
    $display("MISMATCH at %0t: %s hub %h, expected %h", $time, what, got, exp);
    stop_on_error();
  end
endtask

task automatic check_count(string what, row_idx_t got, row_idx_t exp);
  if (got !== exp) begin
    $display("MISMATCH at %0t: %s %0d, expected %0d", $time, what, got, exp);
    stop_on_error();
  end
endtask

task automatic check_word(string what, core_cmd_t got, core_cmd_t exp);
  if (got !== exp) begin
    $display("MISMATCH at %0t: %s word %h, expected %h", $time, what, got, exp);
    stop_on_error();
  end
endtask

`endif

//--- sim/kem_ctrl_tb.sv
`default_nettype none

module kem_ctrl_tb;

  import kem_ctrl_pkg::*;

  localparam int NUM_ROWS    = 3;
  localparam int CYCLE_LIMIT = 1000;

  logic            clk;
  logic            rst_n;
  top_cmd_e        cmd;
  logic            cmd_can_receive;
  core_cmd_t       core_cmd;
  core_unit_mask_t core_has_any;
  logic            core_consume;

  logic            back_pressure = 1'b0;
  logic [31:0]     rng_state;
  logic            held_valid;
  core_unit_mask_t held_mask;
  core_cmd_t       held_word;

  // Transferred steps of the current command and of the reference run
  core_unit_mask_t seen_mask [$];
  core_cmd_t       seen_word [$];
  core_cmd_t       golden_word [$];

  task automatic stop_on_error();
    $display("Some tests failed");
    $fatal(1, "stopped at the first error");
  endtask

  `include "kem_ctrl_ref.svh"

  kem_ctrl_top #(
    .NUM_ROWS(NUM_ROWS)
  ) dut_i (
    .i_clk            (clk),
    .i_rst_n          (rst_n),
    .i_cmd            (cmd),
    .o_cmd_can_receive(cmd_can_receive),
    .o_core_cmd       (core_cmd),
    .o_core_has_any   (core_has_any),
    .i_core_consume   (core_consume)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////
  // Consume driver and step monitor
  ////////////////////////////////////////

  // Outputs are stable at the falling edge, so the transfer is decided here
  initial begin
    core_consume = 1'b0;
    rng_state    = 32'h2c01_46e8;
    held_valid   = 1'b0;
    forever begin
      @(negedge clk);
      if (!rst_n) begin
        core_consume = 1'b0;
        held_valid   = 1'b0;
      end else begin
        if (back_pressure) begin
          rng_state    = xorshift32(rng_state);
          core_consume = |rng_state[1:0];
        end else begin
          core_consume = 1'b1;
        end
        // A step not consumed last cycle must still be there unchanged
        if (held_valid) begin
          check_mask("held step", core_has_any, held_mask);
          check_word("held step", core_cmd, held_word);
        end
        held_valid = (core_has_any != '0) && !core_consume;
        held_mask  = core_has_any;
        held_word  = core_cmd;
        if (core_has_any != '0 && core_consume) begin
          seen_mask.push_back(core_has_any);
          seen_word.push_back(core_cmd);
        end
      end
    end
  end

  task automatic wait_ready(string what);
    int waited;
    waited = 0;
    while (!cmd_can_receive) begin
      @(negedge clk);
      waited++;
      if (waited > CYCLE_LIMIT) begin
        $display("Timeout: controller never became ready %s", what);
        stop_on_error();
      end
    end
  endtask

  // Issue one command and wait until its last step has gone out
  task automatic run_command(top_cmd_e c);
    wait_ready("before the command");
    seen_mask.delete();
    seen_word.delete();
    cmd = c;
    @(negedge clk);
    cmd = cmd_no_cmd;
    wait_ready("at the end of the command");
  endtask

  task automatic verify_run(string name, top_cmd_e c, logic test_run);
    exp_step_t e;
    check_count({name, " step count"}, row_idx_t'(seen_mask.size()),
                expected_count(c, test_run, NUM_ROWS));
    for (int i = 0; i < seen_mask.size(); i++) begin
      e = expected_step(c, test_run, NUM_ROWS, i);
      check_mask($sformatf("%s step %0d", name, i), seen_mask[i], e.mask);
      if (e.has_byte) begin
        check_cmd_field($sformatf("%s step %0d byte", name, i),
                        {1'b0, seen_word[i].k_in_byte}, e.byte_val);
      end
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    rst_n = 1'b0;
    cmd   = cmd_no_cmd;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    if (!cmd_can_receive) begin
      $display("MISMATCH at %0t: controller not ready after reset", $time);
      stop_on_error();
    end
    check_mask("after reset", core_has_any, '0);

    run_command(cmd_add_entropy);
    verify_run("addEntropy", cmd_add_entropy, 1'b0);

    run_command(cmd_keygen);
    verify_run("keygen", cmd_keygen, 1'b0);
    golden_word = seen_word;

    // Seeds come from outside, so every step reads the outer unit
    run_command(cmd_setup_test);
    verify_run("setupTest", cmd_setup_test, 1'b0);
    foreach (seen_word[i]) begin
      check_hub("setupTest source", seen_word[i].h_src, HUB_OUTER);
    end
    run_command(cmd_keygen);
    verify_run("test keygen", cmd_keygen, 1'b1);

    back_pressure = 1'b1;
    run_command(cmd_keygen);
    back_pressure = 1'b0;
    verify_run("stalled keygen", cmd_keygen, 1'b0);
    foreach (seen_word[i]) begin
      check_word($sformatf("stalled step %0d", i), seen_word[i], golden_word[i]);
    end

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+sim
verilog/kem_ctrl_pkg.sv
verilog/step_counter.sv
verilog/phase_decoder.sv
verilog/step_sequencer.sv
verilog/core_cmd_expander.sv
verilog/kem_ctrl_top.sv
sim/kem_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
  --top-module kem_ctrl_tb -f files.f -o kem_ctrl_sim
./obj_dir/kem_ctrl_sim
